/* rtl/tetris_config.svh */
// Tetris board configuration

`ifndef TETRIS_CONFIG_SVH
`define TETRIS_CONFIG_SVH

// board geometry, row 0 at the top
`define TETRIS_BOARD_ROWS 20
`define TETRIS_BOARD_COLS 10

// anchor column of a freshly spawned piece
`define TETRIS_SPAWN_COL 4

// cleared-line counter saturates here
`define TETRIS_SCORE_MAX 255

`define TETRIS_SHAPE_COUNT 7

`endif

/* rtl/tetris_pkg.sv */
// Tetris shared types

`default_nettype none

`include "tetris_config.svh"

package tetris_pkg;

    typedef logic [`TETRIS_BOARD_COLS-1:0] row_t;
    typedef row_t [`TETRIS_BOARD_ROWS-1:0] board_t;

    typedef logic [$clog2(`TETRIS_BOARD_ROWS)-1:0] row_idx_t;
    typedef logic [$clog2(`TETRIS_BOARD_COLS)-1:0] col_idx_t;

    typedef logic [7:0] score_t;

    typedef enum logic [$clog2(`TETRIS_SHAPE_COUNT)-1:0] {
        PIECE_I, PIECE_O, PIECE_L, PIECE_J, PIECE_S, PIECE_Z, PIECE_T
    } piece_t;

    typedef enum logic [2:0] {
        IDLE, SPAWN, FALLING, LANDED, EVAL, GAMEOVER
    } game_state_t;

    typedef struct packed {
        logic blocked_down;
        logic blocked_left;
        logic blocked_right;
    } piece_status_t;

    // one-hot at most
    typedef struct packed {
        logic spawn;
        logic down;
        logic left;
        logic right;
    } piece_cmd_t;

endpackage

`default_nettype wire

/* rtl/piece_engine.sv */
// Falling piece engine

`timescale 1ns/1ps
`default_nettype none

`include "tetris_config.svh"

module piece_engine
    import tetris_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  board_t        board_i,
    input  piece_cmd_t    cmd_i,
    input  piece_t        piece_type_i,
    output board_t        mask_o,
    output piece_status_t status_o
);

    // offset of one cell from the anchor
    typedef struct packed {
        logic [1:0] dr;
        logic [1:0] dc;
    } cell_off_t;

    typedef cell_off_t [3:0] shape_cells_t;

    piece_t       shape_q;
    row_idx_t     row_q;
    col_idx_t     col_q;
    shape_cells_t cells;

    function automatic shape_cells_t shape_cells(input piece_t shape);
        shape_cells_t c;
        case (shape)
            PIECE_I: c = {2'd0, 2'd0, 2'd1, 2'd0, 2'd2, 2'd0, 2'd3, 2'd0};
            PIECE_O: c = {2'd0, 2'd0, 2'd0, 2'd1, 2'd1, 2'd0, 2'd1, 2'd1};
            PIECE_L: c = {2'd0, 2'd0, 2'd1, 2'd0, 2'd2, 2'd0, 2'd2, 2'd1};
            PIECE_J: c = {2'd0, 2'd1, 2'd1, 2'd1, 2'd2, 2'd1, 2'd2, 2'd0};
            PIECE_S: c = {2'd0, 2'd1, 2'd0, 2'd2, 2'd1, 2'd0, 2'd1, 2'd1};
            PIECE_Z: c = {2'd0, 2'd0, 2'd0, 2'd1, 2'd1, 2'd1, 2'd1, 2'd2};
            PIECE_T: c = {2'd0, 2'd1, 2'd1, 2'd0, 2'd1, 2'd1, 2'd1, 2'd2};
            default: c = '0;
        endcase
        return c;
    endfunction

    // piece drawn on an empty board, cells off the board are dropped
    function automatic board_t draw(
        input shape_cells_t c,
        input int           base_row,
        input int           base_col
    );
        board_t m;
        int     r;
        int     col;
        m = '0;
        for (int k = 0; k < 4; k++) begin
            r = base_row + int'(c[k].dr);
            col = base_col + int'(c[k].dc);
            if (r >= 0 && r < `TETRIS_BOARD_ROWS && col >= 0 && col < `TETRIS_BOARD_COLS) begin
                m[r][col] = 1'b1;
            end
        end
        return m;
    endfunction

    // true when every cell lands on the board and on a free cell
    function automatic logic fits(
        input shape_cells_t c,
        input int           base_row,
        input int           base_col,
        input board_t       board
    );
        logic ok;
        int   r;
        int   col;
        ok = 1'b1;
        for (int k = 0; k < 4; k++) begin
            r = base_row + int'(c[k].dr);
            col = base_col + int'(c[k].dc);
            if (r < 0 || r >= `TETRIS_BOARD_ROWS || col < 0 || col >= `TETRIS_BOARD_COLS) begin
                ok = 1'b0;
            end else if (board[r][col]) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            shape_q <= PIECE_I;
            row_q   <= '0;
            col_q   <= '0;
        end else if (cmd_i.spawn) begin
            shape_q <= piece_type_i;
            row_q   <= '0;
            col_q   <= col_idx_t'(`TETRIS_SPAWN_COL);
        end else if (cmd_i.down) begin
            row_q <= row_q + 1'b1;
        end else if (cmd_i.left) begin
            col_q <= col_q - 1'b1;
        end else if (cmd_i.right) begin
            col_q <= col_q + 1'b1;
        end
    end

    assign cells = shape_cells(shape_q);

    assign mask_o = draw(cells, int'(row_q), int'(col_q));

    // each direction checked with the piece shifted one step
    assign status_o.blocked_down  = !fits(cells, int'(row_q) + 1, int'(col_q), board_i);
    assign status_o.blocked_left  = !fits(cells, int'(row_q), int'(col_q) - 1, board_i);
    assign status_o.blocked_right = !fits(cells, int'(row_q), int'(col_q) + 1, board_i);

endmodule

`default_nettype wire

/* rtl/line_clearer.sv */
// Line clear scanner and score

`timescale 1ns/1ps
`default_nettype none

`include "tetris_config.svh"

module line_clearer
    import tetris_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   start_i,
    input  board_t board_i,
    output logic   done_o,
    output board_t board_o,
    output score_t score_o
);

    board_t   work_q;
    row_idx_t scan_q;
    logic     busy_q;
    logic     done_q;
    score_t   score_q;
    logic     row_full;

    assign row_full = &work_q[scan_q];

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            scan_q  <= '0;
            busy_q  <= 1'b0;
            done_q  <= 1'b0;
            score_q <= '0;
        end else begin
            done_q <= 1'b0;
            if (start_i) begin
                scan_q <= row_idx_t'(`TETRIS_BOARD_ROWS - 1);
                busy_q <= 1'b1;
            end else if (busy_q) begin
                if (row_full) begin
                    // same row is examined again after the shift
                    if (score_q != score_t'(`TETRIS_SCORE_MAX)) begin
                        score_q <= score_q + 1'b1;
                    end
                end else if (scan_q == '0) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end else begin
                    scan_q <= scan_q - 1'b1;
                end
            end
        end
    end

    // working copy of the board
    always_ff @(posedge clk) begin
        if (start_i) begin
            work_q <= board_i;
        end else if (busy_q && row_full) begin
            for (int r = 1; r < `TETRIS_BOARD_ROWS; r++) begin
                if (r <= int'(scan_q)) begin
                    work_q[r] <= work_q[r-1];
                end
            end
            work_q[0] <= '0;
        end
    end

    assign done_o  = done_q;
    assign board_o = work_q;
    assign score_o = score_q;

endmodule

`default_nettype wire

/* rtl/game_controller.sv */
// Game state machine and stored board

`timescale 1ns/1ps
`default_nettype none

module game_controller
    import tetris_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          start_i,
    input  logic          tick_i,
    input  logic          left_i,
    input  logic          right_i,
    input  piece_status_t status_i,
    input  board_t        mask_i,
    input  logic          clear_done_i,
    input  board_t        cleared_board_i,
    output piece_cmd_t    cmd_o,
    output logic          clear_start_o,
    output board_t        clear_board_o,
    output board_t        display_o,
    output logic          spawn_o,
    output logic          gameover_o
);

    game_state_t state_q;
    game_state_t state_d;
    board_t      board_q;
    board_t      merged;
    logic        falling;

    assign falling = (state_q == FALLING);
    assign merged  = board_q | mask_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (start_i) begin
                    state_d = SPAWN;
                end
            end
            SPAWN: state_d = FALLING;
            FALLING: begin
                if (tick_i && status_i.blocked_down) begin
                    state_d = LANDED;
                end
            end
            LANDED: state_d = EVAL;
            EVAL: begin
                if (clear_done_i) begin
                    // top row still occupied after clearing ends the game
                    state_d = (|cleared_board_i[0]) ? GAMEOVER : SPAWN;
                end
            end
            GAMEOVER: state_d = GAMEOVER;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            state_q <= IDLE;
            board_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == LANDED) begin
                board_q <= merged;
            end else if (state_q == EVAL && clear_done_i) begin
                board_q <= cleared_board_i;
            end
        end
    end

    // moves only between ticks, left wins over right
    always_comb begin
        cmd_o       = '0;
        cmd_o.spawn = (state_q == SPAWN);
        if (falling) begin
            if (tick_i) begin
                cmd_o.down = !status_i.blocked_down;
            end else if (left_i && !status_i.blocked_left) begin
                cmd_o.left = 1'b1;
            end else if (right_i && !status_i.blocked_right) begin
                cmd_o.right = 1'b1;
            end
        end
    end

    assign clear_start_o = (state_q == LANDED);
    assign clear_board_o = merged;

    assign display_o  = falling ? merged : board_q;
    assign spawn_o    = (state_q == SPAWN);
    assign gameover_o = (state_q == GAMEOVER);

endmodule

`default_nettype wire

/* rtl/tetris_top.sv */
// Tetris engine top level

`timescale 1ns/1ps
`default_nettype none

module tetris_top
    import tetris_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   start_i,
    input  logic   tick_i,
    input  logic   left_i,
    input  logic   right_i,
    input  piece_t piece_type_i,
    output board_t display_o,
    output score_t score_o,
    output logic   spawn_o,
    output logic   gameover_o
);

    piece_status_t status;
    board_t        mask;
    piece_cmd_t    cmd;
    logic          clear_start;
    logic          clear_done;
    board_t        clear_board;
    board_t        cleared_board;

    // collision is checked against the settled cells only
    board_t        stored_board;

    piece_engine u_piece_engine (
        .clk          (clk),
        .reset        (reset),
        .board_i      (stored_board),
        .cmd_i        (cmd),
        .piece_type_i (piece_type_i),
        .mask_o       (mask),
        .status_o     (status)
    );

    line_clearer u_line_clearer (
        .clk     (clk),
        .reset   (reset),
        .start_i (clear_start),
        .board_i (clear_board),
        .done_o  (clear_done),
        .board_o (cleared_board),
        .score_o (score_o)
    );

    game_controller u_game_controller (
        .clk             (clk),
        .reset           (reset),
        .start_i         (start_i),
        .tick_i          (tick_i),
        .left_i          (left_i),
        .right_i         (right_i),
        .status_i        (status),
        .mask_i          (mask),
        .clear_done_i    (clear_done),
        .cleared_board_i (cleared_board),
        .cmd_o           (cmd),
        .clear_start_o   (clear_start),
        .clear_board_o   (clear_board),
        .display_o       (display_o),
        .spawn_o         (spawn_o),
        .gameover_o      (gameover_o)
    );

    // merged board minus the piece is the stored board while falling
    assign stored_board = clear_board & ~mask;

endmodule

`default_nettype wire

/* verification/tetris_tb.sv */
// Tetris engine testbench

`timescale 1ns/1ps
`default_nettype none

`include "tetris_config.svh"

module tetris_tb
    import tetris_pkg::*;
();

    localparam int ROWS        = `TETRIS_BOARD_ROWS;
    localparam int COLS        = `TETRIS_BOARD_COLS;
    localparam int BITS        = ROWS * COLS;
    localparam int CYCLE_LIMIT = 20000;

    typedef logic [BITS-1:0] value_t;

    logic   clk = 1'b0;
    logic   reset;
    logic   start_i;
    logic   tick_i;
    logic   left_i;
    logic   right_i;
    piece_t piece_type_i;
    board_t display_o;
    score_t score_o;
    logic   spawn_o;
    logic   gameover_o;

    // cell offsets per shape, order I O L J S Z T
    int shape_dr [7][4] = '{'{0, 1, 2, 3}, '{0, 0, 1, 1}, '{0, 1, 2, 2}, '{0, 1, 2, 2},
                            '{0, 0, 1, 1}, '{0, 0, 1, 1}, '{0, 1, 1, 1}};
    int shape_dc [7][4] = '{'{0, 0, 0, 0}, '{0, 1, 0, 1}, '{0, 0, 0, 1}, '{1, 1, 1, 0},
                            '{1, 2, 0, 1}, '{0, 1, 1, 2}, '{1, 0, 1, 2}};

    piece_t order [6] = '{PIECE_I, PIECE_L, PIECE_J, PIECE_S, PIECE_Z, PIECE_T};

    // reference model
    board_t m_board;
    int     m_shape;
    int     m_row;
    int     m_col;
    int     m_score;
    logic   m_landed;

    string  test_name;
    int     errors = 0;
    int     passed = 0;
    int     failed = 0;
    int     cycles = 0;

    tetris_top dut_i (
        .clk          (clk),
        .reset        (reset),
        .start_i      (start_i),
        .tick_i       (tick_i),
        .left_i       (left_i),
        .right_i      (right_i),
        .piece_type_i (piece_type_i),
        .display_o    (display_o),
        .score_o      (score_o),
        .spawn_o      (spawn_o),
        .gameover_o   (gameover_o)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    function automatic board_t piece_mask(input int shape, input int row, input int col);
        board_t m;
        m = '0;
        for (int k = 0; k < 4; k++) begin
            m[row + shape_dr[shape][k]][col + shape_dc[shape][k]] = 1'b1;
        end
        return m;
    endfunction

    function automatic logic fits(input int shape, input int row, input int col);
        int r;
        int c;
        for (int k = 0; k < 4; k++) begin
            r = row + shape_dr[shape][k];
            c = col + shape_dc[shape][k];
            if (r < 0 || r >= ROWS || c < 0 || c >= COLS) return 1'b0;
            if (m_board[r][c]) return 1'b0;
        end
        return 1'b1;
    endfunction

    // full rows vanish, everything above drops down
    function automatic board_t clear_rows(input board_t b, output int lines);
        board_t res;
        int     dst;
        res   = '0;
        dst   = ROWS - 1;
        lines = 0;
        for (int r = ROWS - 1; r >= 0; r--) begin
            if (&b[r]) begin
                lines++;
            end else begin
                res[dst] = b[r];
                dst--;
            end
        end
        return res;
    endfunction

    task automatic step();
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic check(input string what, input value_t exp, input value_t act);
        assert (act === exp) else begin
            $display("FAIL %s %s: expected %h, actual %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        errors    = 0;
        @(negedge clk);
        reset   = 1'b1;
        start_i = 1'b0;
        tick_i  = 1'b0;
        left_i  = 1'b0;
        right_i = 1'b0;
        repeat (5) @(negedge clk);
        reset   = 1'b0;
        m_board = '0;
        m_score = 0;
    endtask

    task automatic finish_test();
        if (errors == 0) begin
            passed++;
            $display("test %s: passed", test_name);
        end else begin
            failed++;
            $display("test %s: failed with %0d mismatches", test_name, errors);
        end
    endtask

    task automatic start_game();
        start_i = 1'b1;
        step();
        start_i = 1'b0;
        check("spawn after start", value_t'(1), value_t'(spawn_o));
    endtask

    task automatic spawn_piece(input piece_t shape);
        piece_type_i = shape;
        while (!spawn_o) step();
        step();
        // only the value during SPAWN may matter
        piece_type_i = piece_t'($urandom_range(6));
        m_shape  = int'(shape);
        m_row    = 0;
        m_col    = `TETRIS_SPAWN_COL;
        m_landed = 1'b0;
        check("display at spawn", m_board | piece_mask(m_shape, m_row, m_col), display_o);
    endtask

    task automatic pulse(input logic t, input logic l, input logic r);
        tick_i  = t;
        left_i  = l;
        right_i = r;
        step();
        tick_i  = 1'b0;
        left_i  = 1'b0;
        right_i = 1'b0;
        if (t) begin
            if (fits(m_shape, m_row + 1, m_col)) m_row++;
            else m_landed = 1'b1;
        end else if (l && fits(m_shape, m_row, m_col - 1)) begin
            m_col--;
        end else if (r && fits(m_shape, m_row, m_col + 1)) begin
            m_col++;
        end
        if (m_landed) check("display at landing", m_board, display_o);
        else check("falling display", m_board | piece_mask(m_shape, m_row, m_col), display_o);
    endtask

    // random gaps, and ticks that swallow a move, around each move
    task automatic move(input logic l, input logic r);
        if ($urandom_range(3) == 0) pulse(1'b0, 1'b0, 1'b0);
        if ($urandom_range(3) == 0 && fits(m_shape, m_row + 1, m_col)) pulse(1'b1, l, r);
        pulse(1'b0, l, r);
    endtask

    task automatic drop_piece();
        board_t merged;
        board_t cleared;
        int     lines;
        logic   over;
        while (!m_landed) pulse(1'b1, 1'b0, 1'b0);
        merged  = m_board | piece_mask(m_shape, m_row, m_col);
        cleared = clear_rows(merged, lines);
        over    = |cleared[0];
        step();
        while (!spawn_o && !gameover_o) begin
            check("merged board", merged, display_o);
            step();
        end
        m_board = cleared;
        m_score = m_score + lines;
        if (m_score > `TETRIS_SCORE_MAX) m_score = `TETRIS_SCORE_MAX;
        check("cleared board", m_board, display_o);
        check("score", value_t'(m_score), value_t'(score_o));
        check("gameover", value_t'(over), value_t'(gameover_o));
        check("spawn after clear", value_t'(!over), value_t'(spawn_o));
    endtask

    // random tick and move pulses that must change nothing
    task automatic hold_check(input int n, input logic exp_over);
        repeat (n) begin
            tick_i  = 1'($urandom_range(1));
            left_i  = 1'($urandom_range(1));
            right_i = 1'($urandom_range(1));
            step();
            check("idle display", m_board, display_o);
            check("idle score", value_t'(m_score), value_t'(score_o));
            check("idle gameover", value_t'(exp_over), value_t'(gameover_o));
            check("idle spawn", '0, value_t'(spawn_o));
        end
        tick_i  = 1'b0;
        left_i  = 1'b0;
        right_i = 1'b0;
    endtask

    initial begin
        void'($urandom(32'hf2f54e78));
        reset        = 1'b1;
        start_i      = 1'b0;
        tick_i       = 1'b0;
        left_i       = 1'b0;
        right_i      = 1'b0;
        piece_type_i = PIECE_I;

        begin_test("reset_idle");
        hold_check(30, 1'b0);
        finish_test();

        begin_test("spawn_and_fall");
        start_game();
        spawn_piece(PIECE_O);
        check("O cells", value_t'(4'hf), value_t'({display_o[0][5:4], display_o[1][5:4]}));
        repeat ($urandom_range(6, 3)) pulse(1'b1, 1'b0, 1'b0);
        drop_piece();
        for (int k = 0; k < 6; k++) begin
            spawn_piece(order[k]);
            repeat (5) move(k % 2 == 0, k % 2 == 1);
            drop_piece();
        end
        finish_test();

        begin_test("wall_moves");
        start_game();
        spawn_piece(PIECE_I);
        repeat (7) move(1'b1, 1'b0);
        check("I at left wall", value_t'(4'hf), value_t'({display_o[m_row][0],
            display_o[m_row + 1][0], display_o[m_row + 2][0], display_o[m_row + 3][0]}));
        drop_piece();
        spawn_piece(PIECE_I);
        repeat (9) move(1'b0, 1'b1);
        check("I at right wall", value_t'(4'hf), value_t'({display_o[m_row][9],
            display_o[m_row + 1][9], display_o[m_row + 2][9], display_o[m_row + 3][9]}));
        drop_piece();
        finish_test();

        begin_test("stacking");
        start_game();
        spawn_piece(PIECE_I);
        drop_piece();
        check("floor landing", value_t'(4'hf), value_t'({display_o[16][4], display_o[17][4],
            display_o[18][4], display_o[19][4]}));
        spawn_piece(PIECE_I);
        drop_piece();
        check("stacked landing", value_t'(4'hf), value_t'({display_o[12][4], display_o[13][4],
            display_o[14][4], display_o[15][4]}));
        finish_test();

        begin_test("line_clear");
        start_game();
        for (int c = 0; c < COLS; c++) begin
            spawn_piece(PIECE_I);
            if (c < 4) repeat (4 - c) move(1'b1, 1'b0);
            else repeat (c - 4) move(1'b0, 1'b1);
            drop_piece();
        end
        check("board after clear", '0, display_o);
        check("score after clear", value_t'(4), value_t'(score_o));
        finish_test();

        begin_test("game_over");
        start_game();
        repeat (5) begin
            spawn_piece(PIECE_I);
            drop_piece();
        end
        check("gameover after fifth piece", value_t'(1), value_t'(gameover_o));
        hold_check(30, 1'b1);
        finish_test();

        $display("tests %0d, passed %0d, failed %0d", passed + failed, passed, failed);
        if (failed == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+rtl
rtl/tetris_pkg.sv
rtl/piece_engine.sv
rtl/line_clearer.sv
rtl/game_controller.sv
rtl/tetris_top.sv
verification/tetris_tb.sv

/* run.sh */
#!/bin/sh
# build and run the tetris testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tetris_tb -f list.f -o Vtetris_tb
./obj_dir/Vtetris_tb > sim.log
cat sim.log
if grep -q "FAIL: see errors above" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
